// ==== sources.f ====
+incdir+verilog
verilog/vga_pkg.sv
verilog/vga_sync.sv
verilog/cell_ram.sv
verilog/cell_renderer.sv
verilog/vga_top.sv
verif/vga_chk.sv
verif/vga_tb.sv

// ==== verif/vga_chk.sv ====
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga_chk (
    input logic               clk0,
    input logic               rst_n,
    input logic               pix_en,
    input logic               h_sync,
    input logic               v_sync,
    input logic               blank_n,
    input vga_pkg::cell_col_t cell_col
);

    // set at the first pixel step after reset
    logic seen_step;

    always_ff @(posedge clk0 or negedge rst_n) begin
        if (!rst_n) begin
            seen_step <= 1'b0;
        end else if (pix_en) begin
            seen_step <= 1'b1;
        end
    end

    // outputs hold their reset value until the raster starts
    a_idle_after_reset: assert property (@(posedge clk0) disable iff (!rst_n)
        !seen_step |-> (!h_sync && !blank_n))
        else $error("h_sync or blank_n high before the first pixel step");

    // v_sync only moves on a pixel step
    a_vsync_on_step: assert property (@(posedge clk0) disable iff (!rst_n)
        !pix_en |=> $stable(v_sync))
        else $error("v_sync changed outside a pixel step");

    a_col_range: assert property (@(posedge clk0) disable iff (!rst_n)
        blank_n |-> (cell_col <= (`VGA_COLS - 1)))
        else $error("cell_col beyond the last column while active");

    // sync pulse lies inside horizontal blanking
    a_blank_in_sync: assert property (@(posedge clk0) disable iff (!rst_n)
        !(blank_n && !h_sync))
        else $error("blank_n high during h_sync pulse");

endmodule

bind vga_sync vga_chk chk_i (
    .clk0     (clk0),
    .rst_n    (rst_n),
    .pix_en   (pix_en),
    .h_sync   (h_sync),
    .v_sync   (v_sync),
    .blank_n  (blank_n),
    .cell_col (cell_col)
);

// ==== verif/vga_stim.txt ====
# w col row colour : cell write before the first frame
# r col row colour : cell rewrite in vertical blanking after frame 0
# s test frame x y colour : expected rgb at active pixel x,y of that frame
w 0 0 f00
w 1 0 0f0
w 91 0 00f
w 0 1 123
w 1 1 456
w 8 1 246
w 0 10 369
w 5 10 abc
w 6 10 def
w 45 68 c3c
w 91 68 5a5
# out of range, would alias cells 0/1, 0/10 and 8/1 without the range check
w 92 0 777
w 92 9 888
w 100 0 999
w 3 69 aaa
r 1 0 0ff
r 5 10 f0f
s 4 0 0 0 f00
s 4 0 6 0 f00
s 4 0 7 0 0f0
s 4 0 13 6 0f0
s 4 0 637 0 00f
s 4 0 639 6 00f
s 4 0 7 13 456
s 4 0 35 70 abc
s 4 0 42 76 def
s 4 0 315 476 c3c
s 4 0 639 479 5a5
s 6 0 0 7 123
s 6 0 56 13 246
s 6 0 0 70 369
s 6 1 6 7 123
s 5 1 7 0 0ff
s 5 1 13 6 0ff
s 5 1 35 70 f0f
s 5 1 41 76 f0f
s 5 1 0 0 f00
s 5 1 42 70 def

// ==== verif/vga_tb.sv ====
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga_tb;
    import vga_pkg::*;

    localparam int     RST_CYCLES  = 8;
    localparam int     LINE_CHECKS = 10;
    localparam longint FRAME_CLKS  = `VGA_H_TOTAL * `VGA_V_TOTAL * 2;
    localparam longint WATCHDOG_NS = (3 * FRAME_CLKS + RST_CYCLES) * 100;

    logic      clk0;
    logic      rst_n;
    logic      pix_en;
    logic      wr_en;
    cell_col_t wr_col;
    cell_row_t wr_row;
    color_t    wr_color;
    logic      h_sync_out;
    logic      v_sync_out;
    logic      blank_n_out;
    color_t    rgb;

    // expected memory content, per cell
    color_t model [0:`VGA_ROWS-1][0:`VGA_COLS-1];
    bit     known [0:`VGA_ROWS-1][0:`VGA_COLS-1];
    bit     row_used [0:`VGA_ROWS-1];
    // pending writes, initial and rewrite
    int     q_col[$];
    int     q_row[$];
    color_t q_color[$];
    int     r_col[$];
    int     r_row[$];
    color_t r_color[$];
    // pixel samples from the file
    int     s_test[$];
    int     s_frame[$];
    int     s_x[$];
    int     s_y[$];
    color_t s_color[$];
    int     s_total [1:6];
    int     s_seen [1:6];
    int     err_cnt [1:6];
    bit     reported [1:6];
    logic [31:0] rng;

    // monitor state
    int step_no;
    int last_h_fall;
    bit have_h_fall;
    int lines_done;
    int h_pulses;
    int v_low_pulses;
    int vfalls;
    int blank_run;
    int active_lines;
    int x_pos;
    int y_pos;
    logic prev_h;
    logic prev_v;
    logic prev_b;

    vga_top dut_i (
        .clk0        (clk0),
        .rst_n       (rst_n),
        .pix_en      (pix_en),
        .wr_en       (wr_en),
        .wr_col      (wr_col),
        .wr_row      (wr_row),
        .wr_color    (wr_color),
        .h_sync_out  (h_sync_out),
        .v_sync_out  (v_sync_out),
        .blank_n_out (blank_n_out),
        .rgb         (rgb)
    );

    initial begin
        clk0 = 1'b0;
        forever #50 clk0 = ~clk0;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        begin
            x = s;
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
            return x;
        end
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1: return "line timing";
            2: return "frame timing";
            3: return "active window";
            4: return "cell mapping";
            5: return "rewrite between frames";
            default: return "out of range writes";
        endcase
    endfunction

    // model follows the rule that only in-range cells are written
    task automatic queue_write(input int col, input int row, input color_t c);
        begin
            q_col.push_back(col);
            q_row.push_back(row);
            q_color.push_back(c);
            if (col < `VGA_COLS && row < `VGA_ROWS) begin
                model[row][col] = c;
                known[row][col] = 1'b1;
                row_used[row] = 1'b1;
            end
        end
    endtask

    task automatic load_stim(output bit ok);
        int fd;
        int code;
        int t;
        int f;
        int a;
        int b;
        logic [11:0] c;
        byte kind;
        reg [8*160-1:0] skip;
        begin
            ok = 1'b0;
            fd = $fopen("verif/vga_stim.txt", "r");
            if (fd == 0) begin
                $display("could not open the stimulus file verif/vga_stim.txt");
            end else begin
                ok = 1'b1;
                while (!$feof(fd)) begin
                    code = $fscanf(fd, " %c", kind);
                    if (code != 1) begin
                        break;
                    end
                    if (kind == "#") begin
                        code = $fgets(skip, fd);
                    end else if (kind == "w") begin
                        code = $fscanf(fd, "%d %d %h", a, b, c);
                        queue_write(a, b, c);
                    end else if (kind == "r") begin
                        code = $fscanf(fd, "%d %d %h", a, b, c);
                        r_col.push_back(a);
                        r_row.push_back(b);
                        r_color.push_back(c);
                    end else if (kind == "s") begin
                        code = $fscanf(fd, "%d %d %d %d %h", t, f, a, b, c);
                        s_test.push_back(t);
                        s_frame.push_back(f);
                        s_x.push_back(a);
                        s_y.push_back(b);
                        s_color.push_back(c);
                        s_total[t]++;
                    end
                end
                $fclose(fd);
            end
        end
    endtask

    // one pixel step, with at most one host write riding on it
    task automatic next_pixel();
        begin
            @(negedge clk0);
            pix_en = 1'b1;
            if (q_col.size() > 0) begin
                wr_en    = 1'b1;
                wr_col   = cell_col_t'(q_col.pop_front());
                wr_row   = cell_row_t'(q_row.pop_front());
                wr_color = q_color.pop_front();
            end
            @(negedge clk0);
            pix_en = 1'b0;
            wr_en  = 1'b0;
            step_no++;
        end
    endtask

    task automatic report_test(input int t);
        begin
            if (t == 1 && lines_done < LINE_CHECKS) begin
                $display("test 1: only %0d of %0d lines were measured",
                         lines_done, LINE_CHECKS);
                err_cnt[t]++;
            end
            if (s_seen[t] != s_total[t]) begin
                $display("test %0d: only %0d of %0d pixel samples were reached",
                         t, s_seen[t], s_total[t]);
                err_cnt[t]++;
            end
            if (err_cnt[t] == 0) begin
                $display("test %0d %s: passed", t, test_name(t));
            end else begin
                $display("test %0d %s: failed, %0d errors", t, test_name(t), err_cnt[t]);
            end
            reported[t] = 1'b1;
        end
    endtask

    task automatic check_pixel();
        int frame;
        int tid;
        int cx;
        int cy;
        begin
            frame = vfalls - 1;
            tid = (frame == 0) ? 4 : 5;
            cx = x_pos / `VGA_CELL;
            cy = y_pos / `VGA_CELL;
            if (frame < 0 || frame > 1 || cx >= `VGA_COLS || cy >= `VGA_ROWS) begin
                return;
            end
            if (row_used[cy]) begin
                if (known[cy][cx] && rgb !== model[cy][cx]) begin
                    $display("[ERROR] rgb x=%0d y=%0d: expected 0x%03h, got 0x%03h",
                             x_pos, y_pos, model[cy][cx], rgb);
                    err_cnt[tid]++;
                end
                // literal samples from the file
                for (int i = 0; i < s_x.size(); i++) begin
                    if (s_frame[i] == frame && s_x[i] == x_pos && s_y[i] == y_pos) begin
                        s_seen[s_test[i]]++;
                        if (rgb !== s_color[i]) begin
                            $display("[ERROR] rgb sample x=%0d y=%0d: expected 0x%03h, got 0x%03h",
                                     x_pos, y_pos, s_color[i], rgb);
                            err_cnt[s_test[i]]++;
                        end
                    end
                end
            end
        end
    endtask

    task automatic process_step();
        begin
            if (!blank_n_out && rgb !== 12'h000) begin
                $display("[ERROR] rgb in blanking: expected 0x000, got 0x%03h", rgb);
                err_cnt[3]++;
            end
            // h_sync_out falling edge ends one line
            if (prev_h && !h_sync_out) begin
                if (have_h_fall && lines_done < LINE_CHECKS) begin
                    if (step_no - last_h_fall != `VGA_H_TOTAL) begin
                        $display("[ERROR] h_sync_out period: expected 0x%0h, got 0x%0h",
                                 `VGA_H_TOTAL, step_no - last_h_fall);
                        err_cnt[1]++;
                    end
                    lines_done++;
                    if (lines_done == LINE_CHECKS) begin
                        report_test(1);
                    end
                end
                have_h_fall = 1'b1;
                last_h_fall = step_no;
                h_pulses++;
                if (!v_sync_out) begin
                    v_low_pulses++;
                end
            end
            if (!prev_h && h_sync_out && have_h_fall && lines_done < LINE_CHECKS) begin
                if (step_no - last_h_fall != `VGA_H_SYNC) begin
                    $display("[ERROR] h_sync_out low time: expected 0x%0h, got 0x%0h",
                             `VGA_H_SYNC, step_no - last_h_fall);
                    err_cnt[1]++;
                end
            end
            if (!prev_v && v_sync_out && vfalls > 0 && v_low_pulses != `VGA_V_SYNC) begin
                $display("[ERROR] v_sync_out low lines: expected 0x%0h, got 0x%0h",
                         `VGA_V_SYNC, v_low_pulses);
                err_cnt[2]++;
            end
            // frame boundary
            if (prev_v && !v_sync_out) begin
                if (vfalls > 0 && h_pulses != `VGA_V_TOTAL) begin
                    $display("[ERROR] h_sync_out pulses per frame: expected 0x%0h, got 0x%0h",
                             `VGA_V_TOTAL, h_pulses);
                    err_cnt[2]++;
                end
                if (vfalls > 0 && active_lines != `VGA_V_ACTIVE) begin
                    $display("[ERROR] blank_n_out lines per frame: expected 0x%0h, got 0x%0h",
                             `VGA_V_ACTIVE, active_lines);
                    err_cnt[3]++;
                end
                h_pulses = 0;
                v_low_pulses = 0;
                active_lines = 0;
                y_pos = 0;
                vfalls++;
                if (vfalls == 2) begin
                    report_test(4);
                    // vertical blanking, queue the rewrites now
                    while (r_col.size() > 0) begin
                        queue_write(r_col.pop_front(), r_row.pop_front(), r_color.pop_front());
                    end
                end
            end
            // active window and pixel position
            if (!prev_b && blank_n_out) begin
                blank_run = 0;
                x_pos = 0;
            end
            if (blank_n_out) begin
                check_pixel();
                blank_run++;
                x_pos++;
            end
            if (prev_b && !blank_n_out) begin
                if (blank_run != `VGA_H_ACTIVE) begin
                    $display("[ERROR] blank_n_out active length: expected 0x%0h, got 0x%0h",
                             `VGA_H_ACTIVE, blank_run);
                    err_cnt[3]++;
                end
                active_lines++;
                y_pos++;
            end
            prev_h = h_sync_out;
            prev_v = v_sync_out;
            prev_b = blank_n_out;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: two full frames were not seen in the expected time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int passed;
        int failed;
        int total_err;
        bit stim_ok;
        rst_n    = 1'b0;
        pix_en   = 1'b0;
        wr_en    = 1'b0;
        wr_col   = '0;
        wr_row   = '0;
        wr_color = '0;
        rng      = 32'd15234;
        load_stim(stim_ok);
        if (!stim_ok) begin
            $display("STATUS: FAIL");
            $finish;
        end else begin
            // fill the rest of every row the samples touch
            for (int r = 0; r < `VGA_ROWS; r++) begin
                for (int c = 0; c < `VGA_COLS; c++) begin
                    if (row_used[r] && !known[r][c]) begin
                        rng = xorshift(rng);
                        queue_write(c, r, rng[11:0]);
                    end
                end
            end
            repeat (RST_CYCLES) @(posedge clk0);
            @(negedge clk0);
            rst_n  = 1'b1;
            prev_h = 1'b0;
            prev_v = 1'b0;
            prev_b = 1'b0;
            while (vfalls < 3) begin
                next_pixel();
                process_step();
            end
            passed = 0;
            failed = 0;
            total_err = 0;
            for (int t = 1; t <= 6; t++) begin
                if (!reported[t]) begin
                    report_test(t);
                end
                if (err_cnt[t] == 0) begin
                    passed++;
                end else begin
                    failed++;
                end
                total_err += err_cnt[t];
            end
            $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, total_err);
            if (failed == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== verilog/cell_ram.sv ====
`timescale 1ns/1ps
`include "vga_consts.svh"

module cell_ram (
    input  logic               clk0,
    input  logic               wr_en,
    input  vga_pkg::cell_col_t wr_col,
    input  vga_pkg::cell_row_t wr_row,
    input  vga_pkg::color_t    wr_color,
    input  vga_pkg::cell_col_t rd_col,
    input  vga_pkg::cell_row_t rd_row,
    output vga_pkg::color_t    rd_color
);
    import vga_pkg::*;

    // one colour per cell, simple dual port
    color_t     mem [0:`VGA_CELLS-1];

    cell_addr_t wr_addr;
    cell_addr_t rd_addr;
    logic       wr_ok;

    // row major layout
    assign wr_addr = cell_addr_t'(wr_row) * cell_addr_t'(`VGA_COLS) + cell_addr_t'(wr_col);
    assign rd_addr = cell_addr_t'(rd_row) * cell_addr_t'(`VGA_COLS) + cell_addr_t'(rd_col);

    // col 92..127 or row 69..127 would alias other cells
    assign wr_ok = wr_en && (wr_col < `VGA_COLS) && (wr_row < `VGA_ROWS);

    // host side
    always_ff @(posedge clk0) begin
        if (wr_ok) begin
            mem[wr_addr] <= wr_color;
        end
    end

    // pixel side, registered every clk0
    // same cycle write to this cell still reads the old colour
    always_ff @(posedge clk0) begin
        rd_color <= mem[rd_addr];
    end

endmodule

// ==== verilog/cell_renderer.sv ====
`timescale 1ns/1ps

module cell_renderer (
    input  logic               clk0,
    input  logic               rst_n,
    input  logic               pix_en,
    input  logic               h_sync,
    input  logic               v_sync,
    input  logic               blank_n,
    input  vga_pkg::cell_col_t cell_col,
    input  vga_pkg::cell_row_t cell_row,
    input  vga_pkg::color_t    rd_color,
    output vga_pkg::cell_col_t rd_col,
    output vga_pkg::cell_row_t rd_row,
    output logic               h_sync_out,
    output logic               v_sync_out,
    output logic               blank_n_out,
    output vga_pkg::color_t    rgb
);

    // read address straight from the raster
    // cell_ram returns the colour one clk0 later
    assign rd_col = cell_col;
    assign rd_row = cell_row;

    // sync and blank held one pixel step to match the memory latency
    // pix_en is at most every other clk0, so rd_color has settled
    // by the next pixel step
    always_ff @(posedge clk0 or negedge rst_n) begin
        if (!rst_n) begin
            h_sync_out  <= 1'b0;
            v_sync_out  <= 1'b0;
            blank_n_out <= 1'b0;
        end else if (pix_en) begin
            h_sync_out  <= h_sync;
            v_sync_out  <= v_sync;
            blank_n_out <= blank_n;
        end
    end

    // colour output
    // gated by the blank value going into blank_n_out on this edge,
    // so rgb is zero exactly when blank_n_out is low
    always_ff @(posedge clk0 or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (pix_en) begin
            if (blank_n) begin
                rgb <= rd_color;
            end else begin
                rgb <= '0;
            end
        end
    end

endmodule

// ==== verilog/vga_consts.svh ====
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// horizontal timing in pixels
// order on the line is front porch, sync, back porch, active
`define VGA_H_FRONT   16
`define VGA_H_SYNC    96
`define VGA_H_BACK    48
`define VGA_H_ACTIVE  640

// vertical timing in lines, same order as horizontal
`define VGA_V_FRONT   10
`define VGA_V_SYNC    2
`define VGA_V_BACK    33
`define VGA_V_ACTIVE  480

// blanking region lengths, the active area starts right after these
`define VGA_H_BLANK   (`VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK)
`define VGA_V_BLANK   (`VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK)

// full raster, 800 x 525
`define VGA_H_TOTAL   (`VGA_H_BLANK + `VGA_H_ACTIVE)
`define VGA_V_TOTAL   (`VGA_V_BLANK + `VGA_V_ACTIVE)

// one cell covers 7x7 screen pixels
`define VGA_CELL      7

// cells per line and per frame
// last column holds 3 pixels, last row 4 lines
`define VGA_COLS      92
`define VGA_ROWS      69

// colour memory depth
`define VGA_CELLS     (`VGA_COLS * `VGA_ROWS)

`endif

// ==== verilog/vga_pkg.sv ====
package vga_pkg;

    // raster position, 0..799 horizontal and 0..524 vertical
    typedef logic [9:0] raster_t;

    // cell column, 0..91
    typedef logic [6:0] cell_col_t;

    // cell row, 0..68
    typedef logic [6:0] cell_row_t;

    // flat cell index into the colour memory
    // row * 92 + col, up to 6347
    typedef logic [12:0] cell_addr_t;

    // RGB444 colour
    // red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] color_t;

endpackage

// ==== verilog/vga_sync.sv ====
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga_sync (
    input  logic               clk0,
    input  logic               rst_n,
    input  logic               pix_en,
    output logic               h_sync,
    output logic               v_sync,
    output logic               blank_n,
    output vga_pkg::cell_col_t cell_col,
    output vga_pkg::cell_row_t cell_row
);
    import vga_pkg::*;

    // raster counters and their next values
    raster_t    h_cnt;
    raster_t    v_cnt;
    raster_t    h_next;
    raster_t    v_next;
    // last pixel of the h sync pulse, where the line counter moves
    logic       line_step;
    logic       h_active_next;
    logic       v_active_next;
    // position inside the current cell, 0..6
    logic [2:0] h_sub;
    logic [2:0] v_sub;

    always_comb begin
        line_step = (h_cnt == raster_t'(`VGA_H_FRONT + `VGA_H_SYNC - 1));
        // horizontal wrap at 800
        if (h_cnt == raster_t'(`VGA_H_TOTAL - 1)) begin
            h_next = '0;
        end else begin
            h_next = h_cnt + 1'b1;
        end
        // vertical only moves at the end of h sync
        if (!line_step) begin
            v_next = v_cnt;
        end else if (v_cnt == raster_t'(`VGA_V_TOTAL - 1)) begin
            v_next = '0;
        end else begin
            v_next = v_cnt + 1'b1;
        end
        h_active_next = (h_next >= raster_t'(`VGA_H_BLANK));
        v_active_next = (v_next >= raster_t'(`VGA_V_BLANK));
    end

    // outputs come from next values so they line up with the counters
    always_ff @(posedge clk0 or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            h_sync  <= 1'b0;
            v_sync  <= 1'b0;
            blank_n <= 1'b0;
        end else if (pix_en) begin
            h_cnt   <= h_next;
            v_cnt   <= v_next;
            // low for pixels 16..111
            h_sync  <= !((h_next >= raster_t'(`VGA_H_FRONT)) &&
                         (h_next < raster_t'(`VGA_H_FRONT + `VGA_H_SYNC)));
            // low for lines 10 and 11, updated with the line counter only
            if (line_step) begin
                v_sync <= !((v_next >= raster_t'(`VGA_V_FRONT)) &&
                            (v_next < raster_t'(`VGA_V_FRONT + `VGA_V_SYNC)));
            end
            blank_n <= h_active_next && v_active_next;
        end
    end

    // column counter, held at zero through horizontal blanking
    always_ff @(posedge clk0 or negedge rst_n) begin
        if (!rst_n) begin
            h_sub    <= '0;
            cell_col <= '0;
        end else if (pix_en) begin
            if (!h_active_next) begin
                h_sub    <= '0;
                cell_col <= '0;
            end else if (h_cnt >= raster_t'(`VGA_H_BLANK)) begin
                // first active pixel keeps col 0, later ones count
                if (h_sub == 3'(`VGA_CELL - 1)) begin
                    h_sub    <= '0;
                    cell_col <= cell_col + 1'b1;
                end else begin
                    h_sub <= h_sub + 1'b1;
                end
            end
        end
    end

    // row counter, one tick per line at the line step
    always_ff @(posedge clk0 or negedge rst_n) begin
        if (!rst_n) begin
            v_sub    <= '0;
            cell_row <= '0;
        end else if (pix_en && line_step) begin
            if (!v_active_next) begin
                v_sub    <= '0;
                cell_row <= '0;
            end else if (v_cnt >= raster_t'(`VGA_V_BLANK)) begin
                if (v_sub == 3'(`VGA_CELL - 1)) begin
                    v_sub    <= '0;
                    cell_row <= cell_row + 1'b1;
                end else begin
                    v_sub <= v_sub + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/vga_top.sv ====
`timescale 1ns/1ps

module vga_top (
    input  logic               clk0,
    input  logic               rst_n,
    input  logic               pix_en,
    input  logic               wr_en,
    input  vga_pkg::cell_col_t wr_col,
    input  vga_pkg::cell_row_t wr_row,
    input  vga_pkg::color_t    wr_color,
    output logic               h_sync_out,
    output logic               v_sync_out,
    output logic               blank_n_out,
    output vga_pkg::color_t    rgb
);
    import vga_pkg::*;

    // raster side, vga_sync to renderer
    logic      h_sync;
    logic      v_sync;
    logic      blank_n;
    cell_col_t cell_col;
    cell_row_t cell_row;

    // memory read port
    cell_col_t rd_col;
    cell_row_t rd_row;
    color_t    rd_color;

    vga_sync sync_i (
        .clk0     (clk0),
        .rst_n    (rst_n),
        .pix_en   (pix_en),
        .h_sync   (h_sync),
        .v_sync   (v_sync),
        .blank_n  (blank_n),
        .cell_col (cell_col),
        .cell_row (cell_row)
    );

    // host writes go straight in, no reset on the array
    cell_ram ram_i (
        .clk0     (clk0),
        .wr_en    (wr_en),
        .wr_col   (wr_col),
        .wr_row   (wr_row),
        .wr_color (wr_color),
        .rd_col   (rd_col),
        .rd_row   (rd_row),
        .rd_color (rd_color)
    );

    cell_renderer render_i (
        .clk0        (clk0),
        .rst_n       (rst_n),
        .pix_en      (pix_en),
        .h_sync      (h_sync),
        .v_sync      (v_sync),
        .blank_n     (blank_n),
        .cell_col    (cell_col),
        .cell_row    (cell_row),
        .rd_color    (rd_color),
        .rd_col      (rd_col),
        .rd_row      (rd_row),
        .h_sync_out  (h_sync_out),
        .v_sync_out  (v_sync_out),
        .blank_n_out (blank_n_out),
        .rgb         (rgb)
    );

endmodule
